// File: Bender.yml
package:
  name: rv_byte

export_include_dirs:
  - src

sources:
  - files:
      - src/rv_byte_pkg.sv
      - src/rv_dec_if.sv
      - src/rv_sequencer.sv
      - src/rv_decode.sv
      - src/rv_regfile.sv
      - src/rv_execute.sv
      - src/rv_byte_core.sv
  - target: test
    files:
      - dv/rv_byte_checker.sv
      - dv/rv_byte_assert.sv
      - dv/tb_rv_byte.sv

// File: dv/rv_byte_assert.sv
// bound into rv_byte_core; the write-run counter starts counting at the first reset edge
`timescale 1ns/1ps

module rv_byte_assert (
  input logic               clk,
  input logic               rst,
  input logic               hold,
  input logic               wren,
  input rv_byte_pkg::addr_t address
);
  int         fail_cnt = 0;
  logic [2:0] wr_run;   // consecutive wren cycles

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_run <= '0;
    end else if (wren) begin
      wr_run <= wr_run + 3'd1;
    end else begin
      wr_run <= '0;
    end
  end

  wren_low_in_reset: assert property (@(posedge clk) rst |=> !wren)
    else begin
      fail_cnt++;
      $error("wren high in a reset cycle");
    end

  wren_low_in_hold: assert property (@(posedge clk) hold |-> !wren)
    else begin
      fail_cnt++;
      $error("wren high while hold is high");
    end

  addr_frozen: assert property (@(posedge clk) disable iff (rst) hold |=> $stable(address))
    else begin
      fail_cnt++;
      $error("address moved during hold");
    end

  short_write_run: assert property (@(posedge clk) disable iff (rst) wr_run <= 3'd4)
    else begin
      fail_cnt++;
      $error("wren high for more than four cycles in a row");
    end

endmodule

bind rv_byte_core rv_byte_assert asrt_i (
  .clk     (clk),
  .rst     (rst),
  .hold    (hold),
  .wren    (wren),
  .address (address)
);

// File: dv/rv_byte_checker.sv
// mailbox is the word at 16'h0100; a test closes on the first unheld cycle without wren after a mailbox write
`timescale 1ns/1ps

module rv_byte_checker (
  input  logic               clk,
  input  logic               hold,
  input  rv_byte_pkg::addr_t address,
  input  rv_byte_pkg::byte_t data_out,
  input  logic               wren,
  output logic               done,
  output int                 fails
);
  import rv_byte_pkg::*;

  localparam addr_t mbox_addr = 16'h0100;
  localparam int    budget    = 180; // cycles per test, reset included

  string name;
  word_t exp_val;
  int    exp_wr;
  word_t mbox;
  logic  seen;
  logic  active;
  logic  in_order;
  logic [1:0] next_lane; // lane of the next mailbox byte
  int    writes;
  int    cycles;
  int    passes;

  initial begin
    done   = 1'b0;
    active = 1'b0;
    fails  = 0;
    passes = 0;
  end

  task automatic begin_test(string n, word_t e, int w);
    name      = n;
    exp_val   = e;
    exp_wr    = w;
    mbox      = '0;
    seen      = 1'b0;
    in_order  = 1'b1;
    next_lane = 2'd0;
    writes    = 0;
    cycles    = 0;
    done      = 1'b0;
    active    = 1'b1;
  endtask

  task automatic close_test();
    active = 1'b0;
    done   <= 1'b1;
    if (!seen) begin
      fails++;
      $display("test %s wrote nothing to the mailbox within %0d cycles", name, budget);
    end else if (mbox !== exp_val) begin
      fails++;
      $display("FAIL %s mailbox expected %h actual %h", name, exp_val, mbox);
    end else if (writes != exp_wr) begin
      fails++;
      $display("FAIL %s write cycles expected %0d actual %0d", name, exp_wr, writes);
    end else if (!in_order) begin
      fails++;
      $display("test %s wrote the mailbox bytes out of address order", name);
    end else begin
      passes++;
      $display("pass %s mailbox %h, %0d write cycles", name, mbox, writes);
    end
  endtask

  task automatic print_summary(int assert_errs);
    $display("%0d passed, %0d failed, %0d assertion errors", passes, fails, assert_errs);
  endtask

  always @(posedge clk) begin
    if (active) begin
      cycles++;
      if (wren) begin
        writes++;
        if (address[15:2] == mbox_addr[15:2]) begin
          seen = 1'b1;
          if (address[1:0] != next_lane) in_order = 1'b0; // least significant byte first
          next_lane = next_lane + 2'd1;
          mbox[8 * address[1:0] +: 8] = data_out; // byte lane from address
        end
      end else if (seen && !hold) begin
        close_test();
      end else if (cycles > budget) begin
        close_test();
      end
    end
  end

endmodule

// File: dv/tb_rv_byte.sv
// mailbox word at 16'h0100; each program ends in JAL x0,0 and memory reads follow address combinationally
`timescale 1ns/1ps
`include "rv_byte_cfg.svh"

module tb_rv_byte;
  import rv_byte_pkg::*;

  localparam word_t jal_self = 32'h0000006f; // jal x0,0

  logic  clk;
  logic  rst;
  logic  hold;
  byte_t data_in;
  addr_t address;
  byte_t data_out;
  logic  wren;
  logic  test_done;
  int    chk_fails;
  int    cyc;

  byte_t mem [1 << `RV_ADDR_W];

  // test table, one entry per index, programs flattened eight words each
  string t_name [$];
  word_t t_prog [$];
  int    t_hs [$];
  int    t_hl [$];
  word_t t_exp [$];
  int    t_nwr [$];
  word_t pgm [$];

  rv_byte_core dut_i (
    .clk      (clk),
    .rst      (rst),
    .hold     (hold),
    .data_in  (data_in),
    .address  (address),
    .data_out (data_out),
    .wren     (wren)
  );

  rv_byte_checker chk_i (
    .clk      (clk),
    .hold     (hold),
    .address  (address),
    .data_out (data_out),
    .wren     (wren),
    .done     (test_done),
    .fails    (chk_fails)
  );

  assign data_in = mem[address]; // asynchronous read

  always @(posedge clk) begin
    if (wren) mem[address] <= data_out;
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic word_t r_op(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic word_t i_op(logic [2:0] f3, logic [4:0] rd, rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic word_t addi(logic [4:0] rd, rs1, logic [11:0] imm);
    return i_op(3'b000, rd, rs1, imm);
  endfunction

  function automatic word_t u_op(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic word_t st(logic [2:0] f3, logic [4:0] rs2, rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic word_t sw_mbox(logic [4:0] rs2);
    return st(3'b010, rs2, 5'd0, 12'h100); // base x0
  endfunction

  function automatic word_t br(logic [2:0] f3, logic [4:0] rs1, rs2, logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic word_t jal(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic word_t jalr(logic [4:0] rd, rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'h67};
  endfunction

  task automatic add_test(string name, int hs, int hl, word_t exp, int nwr);
    while (pgm.size() < 8) pgm.push_back(jal_self);
    foreach (pgm[i]) t_prog.push_back(pgm[i]);
    t_name.push_back(name);
    t_hs.push_back(hs);
    t_hl.push_back(hl);
    t_exp.push_back(exp);
    t_nwr.push_back(nwr);
  endtask

  // x1 = -1, x2 = 1; result 1 when taken, 2 when the skipped addi runs
  task automatic add_branch(string name, logic [2:0] f3, word_t exp);
    pgm = '{addi(1, 0, 12'hfff), addi(2, 0, 12'd1), addi(5, 0, 12'd1), br(f3, 1, 2, 13'd8),
            addi(5, 0, 12'd2), sw_mbox(5), jal_self};
    add_test(name, 0, 0, exp, 4);
  endtask

  // x1 = 32'h12345678 then one store to the mailbox
  task automatic add_store(string name, logic [2:0] f3, int hs, int hl, word_t exp, int nwr);
    pgm = '{u_op(7'h37, 1, 20'h12345), addi(1, 1, 12'h678), st(f3, 1, 0, 12'h100), jal_self};
    add_test(name, hs, hl, exp, nwr);
  endtask

  task automatic build_table();
    pgm = '{addi(1, 0, 12'd100), addi(2, 0, 12'hfe2), r_op(7'h00, 3'b000, 3, 1, 2),
            r_op(7'h20, 3'b000, 4, 2, 3), sw_mbox(4), jal_self};
    add_test("add_sub", 0, 0, 32'hffffff9c, 4);
    pgm = '{addi(1, 0, 12'h5a5), i_op(3'b100, 2, 1, 12'hfff), addi(3, 0, 12'h0f0),
            r_op(7'h00, 3'b111, 4, 2, 3), r_op(7'h00, 3'b110, 5, 4, 1), sw_mbox(5), jal_self};
    add_test("xori_and_or", 0, 0, 32'h000005f5, 4);
    pgm = '{addi(1, 0, 12'hfff), i_op(3'b001, 2, 1, 12'd28), addi(3, 0, 12'd4),
            r_op(7'h20, 3'b101, 4, 2, 3), r_op(7'h00, 3'b101, 5, 2, 3),
            r_op(7'h00, 3'b100, 6, 4, 5), sw_mbox(6), jal_self};
    add_test("slli_sra_srl", 0, 0, 32'hf0000000, 4);
    pgm = '{addi(1, 0, 12'hffb), addi(2, 0, 12'd3), r_op(7'h00, 3'b010, 3, 1, 2),
            r_op(7'h00, 3'b011, 4, 1, 2), i_op(3'b001, 5, 3, 12'd1),
            r_op(7'h00, 3'b110, 6, 5, 4), sw_mbox(6), jal_self};
    add_test("slt_sltu", 0, 0, 32'h00000002, 4);
    pgm = '{u_op(7'h37, 1, 20'habcde), u_op(7'h17, 2, 20'h00010), r_op(7'h00, 3'b000, 3, 1, 2),
            sw_mbox(3), jal_self};
    add_test("lui_auipc", 0, 0, 32'habcee004, 4);
    add_branch("beq", 3'b000, 32'd2);
    add_branch("bne", 3'b001, 32'd1);
    add_branch("blt", 3'b100, 32'd1);
    add_branch("bge", 3'b101, 32'd2);
    add_branch("bltu", 3'b110, 32'd2);
    add_branch("bgeu", 3'b111, 32'd1);
    // x1 = 4 from jal, x2 = 12 from jalr, target 17 lands on 16
    pgm = '{jal(1, 21'd8), addi(5, 0, 12'hfff), jalr(2, 1, 12'd13), addi(5, 0, 12'hfff),
            jal(0, 21'd4), r_op(7'h00, 3'b000, 5, 1, 2), sw_mbox(5), jal_self};
    add_test("jal_jalr", 0, 0, 32'h00000010, 4);
    add_store("sb", 3'b000, 0, 0, 32'h00000078, 1);
    add_store("sh", 3'b001, 0, 0, 32'h00005678, 2);
    add_store("sw", 3'b010, 0, 0, 32'h12345678, 4);
    add_store("sw_hold_fetch", 3'b010, 6, 5, 32'h12345678, 4);
    add_store("sw_hold_store", 3'b010, 16, 2, 32'h12345678, 4);
  endtask

  task automatic load_program(int t);
    for (int a = 0; a < (1 << `RV_ADDR_W); a++) begin
      mem[a] <= byte_t'(a[7:0] ^ a[15:8] ^ 8'h3c);
    end
    for (int i = 0; i < 8; i++) begin
      for (int b = 0; b < 4; b++) begin
        mem[4 * i + b] <= t_prog[8 * t + i][8 * b +: 8];
      end
    end
  endtask

  initial begin
    rst  = 1'b1;
    hold = 1'b0;
    build_table();
    for (int t = 0; t < t_name.size(); t++) begin
      @(posedge clk);
      rst  <= 1'b1;
      hold <= 1'b0;
      load_program(t);
      chk_i.begin_test(t_name[t], t_exp[t], t_nwr[t]);
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      cyc = 0;
      while (!test_done) begin
        @(posedge clk);
        cyc++;
        if (t_hl[t] > 0 && cyc == t_hs[t]) hold <= 1'b1;
        if (cyc == t_hs[t] + t_hl[t]) hold <= 1'b0;
      end
    end
    @(posedge clk);
    chk_i.print_summary(dut_i.asrt_i.fail_cnt);
    if (chk_fails == 0 && dut_i.asrt_i.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // budget of 200 cycles per test plus the first reset
  initial begin
    #1;
    #((t_name.size() * 200 + 16) * 20);
    $display("watchdog expired before the last test finished");
    $display("tests failed");
    $finish;
  end

endmodule

// File: src/rv_byte_cfg.svh
// 16-bit byte address space, pc starts at zero, register count fixed at 32 by the RV32I decode
`ifndef RV_BYTE_CFG_SVH
`define RV_BYTE_CFG_SVH

// external address bus width, pc is truncated to this
`define RV_ADDR_W 16

// pc value after reset
`define RV_START_ADDR 16'h0000

// architectural registers, x0 included
`define RV_NREGS 32

`endif

// File: src/rv_byte_core.sv
// byte-serial RV32I core without loads or CSRs; hold freezes everything and forces wren low
`timescale 1ns/1ps

module rv_byte_core (
  input  logic               clk,
  input  logic               rst,
  input  logic               hold,
  input  rv_byte_pkg::byte_t data_in,
  output rv_byte_pkg::addr_t address,
  output rv_byte_pkg::byte_t data_out,
  output logic               wren
);
  import rv_byte_pkg::*;

  word_t    inst;
  addr_t    pc;
  logic     exec;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     wb_en;
  reg_idx_t wb_idx;
  word_t    wb_data;
  addr_t    next_pc;
  logic     store_req;
  addr_t    store_addr;
  word_t    store_data;
  funct3_t  store_size;

  rv_dec_if dec_if ();

  rv_sequencer seq_i (
    .clk        (clk),
    .rst        (rst),
    .hold       (hold),
    .data_in    (data_in),
    .next_pc    (next_pc),
    .store_req  (store_req),
    .store_addr (store_addr),
    .store_data (store_data),
    .store_size (store_size),
    .address    (address),
    .data_out   (data_out),
    .wren       (wren),
    .inst       (inst),
    .pc         (pc),
    .exec       (exec)
  );

  rv_decode dec_i (
    .inst (inst),
    .dec  (dec_if.dec)
  );

  rv_regfile rf_i (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec_if.rf),
    .wb_en    (wb_en),
    .wb_idx   (wb_idx),
    .wb_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute exe_i (
    .exec       (exec),
    .pc         (pc),
    .dec        (dec_if.exe),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .wb_en      (wb_en),
    .wb_idx     (wb_idx),
    .wb_data    (wb_data),
    .next_pc    (next_pc),
    .store_req  (store_req),
    .store_addr (store_addr),
    .store_data (store_data),
    .store_size (store_size)
  );

endmodule

// File: src/rv_byte_pkg.sv
// shared types for the byte-serial core; addr_t narrows the RV32I pc to RV_ADDR_W bits
`include "rv_byte_cfg.svh"

package rv_byte_pkg;

  typedef logic [31:0]           word_t;    // register values, operands, results
  typedef logic [`RV_ADDR_W-1:0] addr_t;    // pc and bus address
  typedef logic [7:0]            byte_t;    // bus data
  typedef logic [4:0]            reg_idx_t; // register index
  typedef logic [2:0]            funct3_t;  // function field, store size too

  // one phase per unheld cycle
  typedef enum logic [2:0] {
    PH_FETCH0,
    PH_FETCH1,
    PH_FETCH2,
    PH_FETCH3,
    PH_EXEC,
    PH_STORE
  } seq_state_t;

  // loads, fences and system ops all land on CL_NOP
  typedef enum logic [3:0] {
    CL_LUI,
    CL_AUIPC,
    CL_JAL,
    CL_JALR,
    CL_BRANCH,
    CL_STORE,
    CL_OPIMM,
    CL_OP,
    CL_NOP
  } op_class_t;

endpackage

// File: src/rv_dec_if.sv
// decoded fields are combinational from the held instruction word and valid only in EXEC and STORE
`timescale 1ns/1ps

interface rv_dec_if;
  import rv_byte_pkg::*;

  op_class_t op_class;
  funct3_t   funct3;
  logic      alt;      // SUB or SRA
  reg_idx_t  rd;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  word_t     imm;      // already sign-extended

  modport dec (output op_class, funct3, alt, rd, rs1, rs2, imm);

  modport rf (input rs1, rs2);

  modport exe (input op_class, funct3, alt, rd, rs1, rs2, imm);

endinterface

// File: src/rv_decode.sv
// RV32I base decode only; loads, FENCE, SYSTEM and undefined encodings come out as CL_NOP
`timescale 1ns/1ps

module rv_decode (
  input rv_byte_pkg::word_t inst,
  rv_dec_if.dec             dec
);
  import rv_byte_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  funct3_t    f3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = inst[6:0];
  assign funct7 = inst[31:25];
  assign f3     = inst[14:12];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec.op_class = CL_NOP;
    case (opcode)
      7'b0110111: dec.op_class = CL_LUI;
      7'b0010111: dec.op_class = CL_AUIPC;
      7'b1101111: dec.op_class = CL_JAL;
      7'b1100111: if (f3 == 3'b000) dec.op_class = CL_JALR;
      7'b1100011: if (f3[2:1] != 2'b01) dec.op_class = CL_BRANCH; // 010/011 undefined
      7'b0100011: if (f3 <= 3'b010) dec.op_class = CL_STORE;
      7'b0010011: begin
        if (f3 == 3'b001) begin
          if (funct7 == 7'b0000000) dec.op_class = CL_OPIMM;
        end else if (f3 == 3'b101) begin
          if (funct7 == 7'b0000000 || funct7 == 7'b0100000) dec.op_class = CL_OPIMM;
        end else begin
          dec.op_class = CL_OPIMM;
        end
      end
      7'b0110011: begin
        if (funct7 == 7'b0000000) dec.op_class = CL_OP;
        else if (funct7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101))
          dec.op_class = CL_OP; // SUB, SRA
      end
      default: dec.op_class = CL_NOP;
    endcase
  end

  always_comb begin
    case (dec.op_class)
      CL_LUI, CL_AUIPC: dec.imm = imm_u;
      CL_JAL:           dec.imm = imm_j;
      CL_JALR, CL_OPIMM: dec.imm = imm_i;
      CL_BRANCH:        dec.imm = imm_b;
      CL_STORE:         dec.imm = imm_s;
      default:          dec.imm = '0;
    endcase
  end

  // only OP and the OPIMM right shifts look at bit 30
  assign dec.alt = (dec.op_class == CL_OP) ||
                   (dec.op_class == CL_OPIMM && f3 == 3'b101) ? inst[30] : 1'b0;

  assign dec.funct3 = f3;
  assign dec.rd     = inst[11:7];
  assign dec.rs1    = inst[19:15];
  assign dec.rs2    = inst[24:20];

endmodule

// File: src/rv_execute.sv
// single-cycle RV32I execute; targets wrap at RV_ADDR_W bits and no misalignment trap exists
`timescale 1ns/1ps

module rv_execute (
  input  logic                  exec,
  input  rv_byte_pkg::addr_t    pc,
  rv_dec_if.exe                 dec,
  input  rv_byte_pkg::word_t    rs1_data,
  input  rv_byte_pkg::word_t    rs2_data,
  output logic                  wb_en,
  output rv_byte_pkg::reg_idx_t wb_idx,
  output rv_byte_pkg::word_t    wb_data,
  output rv_byte_pkg::addr_t    next_pc,
  output logic                  store_req,
  output rv_byte_pkg::addr_t    store_addr,
  output rv_byte_pkg::word_t    store_data,
  output rv_byte_pkg::funct3_t  store_size
);
  import rv_byte_pkg::*;

  word_t      op_b;
  word_t      alu_res;
  word_t      pc_w;
  word_t      link;
  word_t      rs1_imm;   // JALR target and store address
  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;
  logic       take;

  assign pc_w    = word_t'(pc);
  assign link    = pc_w + 32'd4;
  assign rs1_imm = rs1_data + dec.imm;

  // branches compare against rs2, so one comparator serves SLT and Bxx
  assign op_b  = (dec.op_class == CL_OPIMM) ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];
  assign eq    = (rs1_data == op_b);
  assign lt    = ($signed(rs1_data) < $signed(op_b));
  assign ltu   = (rs1_data < op_b);

  always_comb begin
    case (dec.funct3)
      3'b000:  alu_res = dec.alt ? rs1_data - op_b : rs1_data + op_b;
      3'b001:  alu_res = rs1_data << shamt;
      3'b010:  alu_res = {31'b0, lt};
      3'b011:  alu_res = {31'b0, ltu};
      3'b100:  alu_res = rs1_data ^ op_b;
      3'b101:  alu_res = dec.alt ? word_t'($signed(rs1_data) >>> shamt) : rs1_data >> shamt;
      3'b110:  alu_res = rs1_data | op_b;
      default: alu_res = rs1_data & op_b;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      3'b000:  take = eq;   // BEQ
      3'b001:  take = !eq;  // BNE
      3'b100:  take = lt;
      3'b101:  take = !lt;  // BGE
      3'b110:  take = ltu;
      3'b111:  take = !ltu; // BGEU
      default: take = 1'b0;
    endcase
  end

  always_comb begin
    next_pc = pc + addr_t'(4);
    case (dec.op_class)
      CL_JAL:    next_pc = pc + addr_t'(dec.imm);
      CL_JALR:   next_pc = addr_t'(rs1_imm) & ~addr_t'(1); // bit 0 cleared
      CL_BRANCH: if (take) next_pc = pc + addr_t'(dec.imm);
      default:   next_pc = pc + addr_t'(4);
    endcase
  end

  always_comb begin
    wb_en   = exec;
    wb_data = '0;
    case (dec.op_class)
      CL_LUI:          wb_data = dec.imm;
      CL_AUIPC:        wb_data = pc_w + dec.imm;
      CL_JAL, CL_JALR: wb_data = link;
      CL_OPIMM, CL_OP: wb_data = alu_res;
      default:         wb_en   = 1'b0; // branch, store, nop
    endcase
  end

  assign wb_idx = dec.rd;

  // inst and rs2 stay put through STORE, so these need no latching
  assign store_req  = exec && (dec.op_class == CL_STORE);
  assign store_addr = addr_t'(rs1_imm);
  assign store_data = rs2_data;
  assign store_size = dec.funct3;

endmodule

// File: src/rv_regfile.sv
// 32 registers only, x0 hardwired to zero; reads are combinational, write lands at the clock edge
`timescale 1ns/1ps
`include "rv_byte_cfg.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  rv_dec_if.rf                  dec,
  input  logic                  wb_en,
  input  rv_byte_pkg::reg_idx_t wb_idx,
  input  rv_byte_pkg::word_t    wb_data,
  output rv_byte_pkg::word_t    rs1_data,
  output rv_byte_pkg::word_t    rs2_data
);
  import rv_byte_pkg::*;

  word_t regs [`RV_NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_idx != '0) begin // x0 writes dropped
      regs[wb_idx] <= wb_data;
    end
  end

  assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
  assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule

// File: src/rv_sequencer.sv
// strict four fetch cycles, one EXEC, then 1/2/4 STORE cycles; memory reads must be asynchronous
`timescale 1ns/1ps
`include "rv_byte_cfg.svh"

module rv_sequencer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 hold,
  input  rv_byte_pkg::byte_t   data_in,
  input  rv_byte_pkg::addr_t   next_pc,
  input  logic                 store_req,
  input  rv_byte_pkg::addr_t   store_addr,
  input  rv_byte_pkg::word_t   store_data,
  input  rv_byte_pkg::funct3_t store_size,
  output rv_byte_pkg::addr_t   address,
  output rv_byte_pkg::byte_t   data_out,
  output logic                 wren,
  output rv_byte_pkg::word_t   inst,
  output rv_byte_pkg::addr_t   pc,
  output logic                 exec
);
  import rv_byte_pkg::*;

  seq_state_t state;
  logic [1:0] byte_cnt;    // store byte number
  logic [1:0] store_last;
  logic [1:0] fetch_ofs;

  always_comb begin
    case (store_size[1:0])
      2'b00:   store_last = 2'd0; // SB
      2'b01:   store_last = 2'd1; // SH
      default: store_last = 2'd3; // SW
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= PH_FETCH0;
      pc       <= `RV_START_ADDR;
      byte_cnt <= '0;
    end else if (!hold) begin
      case (state)
        PH_FETCH0: state <= PH_FETCH1;
        PH_FETCH1: state <= PH_FETCH2;
        PH_FETCH2: state <= PH_FETCH3;
        PH_FETCH3: state <= PH_EXEC;
        PH_EXEC: begin
          pc       <= next_pc;
          byte_cnt <= '0;
          state    <= store_req ? PH_STORE : PH_FETCH0;
        end
        PH_STORE: begin
          byte_cnt <= byte_cnt + 2'd1;
          if (byte_cnt == store_last) state <= PH_FETCH0;
        end
        default: state <= PH_FETCH0;
      endcase
    end
  end

  // little-endian assembly, one byte per fetch phase
  always_ff @(posedge clk) begin
    if (!hold) begin
      case (state)
        PH_FETCH0: inst[7:0]   <= data_in;
        PH_FETCH1: inst[15:8]  <= data_in;
        PH_FETCH2: inst[23:16] <= data_in;
        PH_FETCH3: inst[31:24] <= data_in;
        default:   inst        <= inst;
      endcase
    end
  end

  always_comb begin
    case (state)
      PH_FETCH1: fetch_ofs = 2'd1;
      PH_FETCH2: fetch_ofs = 2'd2;
      PH_FETCH3: fetch_ofs = 2'd3;
      default:   fetch_ofs = 2'd0;
    endcase
  end

  assign address  = (state == PH_STORE) ? store_addr + addr_t'(byte_cnt)
                                        : pc + addr_t'(fetch_ofs);
  assign data_out = (state == PH_STORE) ? store_data[{byte_cnt, 3'b000} +: 8] : '0;
  assign wren     = (state == PH_STORE) && !hold;
  assign exec     = (state == PH_EXEC) && !hold; // one-cycle strobe, held off while frozen

endmodule

// File: verilog.f
+incdir+src
src/rv_byte_pkg.sv
src/rv_dec_if.sv
src/rv_sequencer.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_byte_core.sv
dv/rv_byte_checker.sv
dv/rv_byte_assert.sv
dv/tb_rv_byte.sv
